// File: common/fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// pc, link hint and load address
`define LEN_WORD 32

// one instruction
`define LEN_INST 32

// line address, 64 lines in the instruction memory
`define LEN_MEMISTR_ADDR 6

// log2 of instructions per line
`define LOG_FETCH_PARA 1
`define FETCH_PARA (1 << `LOG_FETCH_PARA)

// sequential prefetch candidates
`define FETCH_PREDICT_SIZE 4

// line cache entries
`define DEPTH_FETCH_CACHE 8

`endif

// File: common/fetch_pkg.sv
`include "fetch_config.svh"

package fetch_pkg;

    typedef logic [`LEN_MEMISTR_ADDR-1:0] line_addr_t;

    // slot i of a line sits at index i
    typedef logic [`FETCH_PARA-1:0][`LEN_INST-1:0] cache_line_t;

    typedef struct packed {
        logic [`LEN_WORD-`LEN_MEMISTR_ADDR-`LOG_FETCH_PARA-3:0] upper;
        line_addr_t                                         line;
        logic [`LOG_FETCH_PARA-1:0]                         slot;
        logic [1:0]                                         byte_off;
    } fetch_addr_fields_t;

    // raw word or line/slot view of the same address
    typedef union packed {
        logic [`LEN_WORD-1:0] word;
        fetch_addr_fields_t   f;
    } fetch_addr_u;

    typedef struct packed {
        logic                 order;
        logic [`LEN_WORD-1:0] pc;
    } fetch_req_t;

    typedef struct packed {
        logic       valid;
        line_addr_t addr;
    } mem_access_t;

endpackage

// File: common/load_pkg.sv
`include "fetch_config.svh"

package load_pkg;

    // program load port, mode gates all fetching
    typedef struct packed {
        logic                 mode;
        logic                 valid;
        logic [`LEN_WORD-1:0] pc;
        logic [`LEN_INST-1:0] data;
    } load_req_t;

    // one enable per instruction slot
    typedef logic [`FETCH_PARA-1:0] slot_wen_t;

endpackage

// File: fetch/fetch_ctrl.sv
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_ctrl
    import fetch_pkg::*;
    import load_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  fetch_req_t                            req,
    input  logic [`LEN_WORD-1:0]                  lr,
    input  load_req_t                             load,
    input  logic                                  hit,
    output line_addr_t                            req_line,
    output line_addr_t                            hint_line,
    output line_addr_t [`FETCH_PREDICT_SIZE-1:0]  predict_lines,
    input  logic [`FETCH_PREDICT_SIZE-1:0]        predict_hit,
    input  logic [`FETCH_PREDICT_SIZE-1:0]        predict_busy,
    input  logic                                  hint_hit,
    input  logic                                  hint_busy,
    output mem_access_t                           access,
    output slot_wen_t                             wen,
    output logic [`LEN_INST-1:0]                  wdata,
    output logic                                  flush
);

    fetch_addr_u                    pc_a;
    fetch_addr_u                    lr_a;
    fetch_addr_u                    load_a;
    line_addr_t                     last_found;
    line_addr_t                     next_last_found;
    line_addr_t                     base;
    logic                           miss;
    logic [`FETCH_PREDICT_SIZE-1:0] predict_free;
    logic                           hint_free;
    logic                           pick_any;
    line_addr_t                     pick_line;
    mem_access_t                    next_access;
    slot_wen_t                      next_wen;
    logic                           access_valid_q;
    line_addr_t                     access_addr_q;
    logic                           mode_q;

    assign pc_a      = req.pc;
    assign lr_a      = lr;
    assign load_a    = load.pc;
    assign req_line  = pc_a.f.line;
    assign hint_line = lr_a.f.line;

    // a failed lookup re-bases the prediction on the missed line
    assign miss            = req.order & ~hit;
    assign next_last_found = (req.order & hit) ? req_line : last_found;
    assign base            = miss ? req_line : next_last_found;

    always_comb begin
        for (int i = 0; i < `FETCH_PREDICT_SIZE; i++) begin
            predict_lines[i] = base + line_addr_t'(i);
        end
    end

    assign predict_free = ~(predict_hit | predict_busy);
    assign hint_free    = ~(hint_hit | hint_busy);

    // later candidate wins, so larger lines go first
    always_comb begin
        pick_any  = 1'b0;
        pick_line = predict_lines[0];
        for (int i = 0; i < `FETCH_PREDICT_SIZE; i++) begin
            if (predict_free[i]) begin
                pick_any  = 1'b1;
                pick_line = predict_lines[i];
            end
        end
    end

    // in load mode the address carries the write line
    always_comb begin
        next_access.valid = ~load.mode & (pick_any | hint_free);
        next_access.addr  = load.mode ? load_a.f.line
                          : (pick_any ? pick_line : hint_line);
    end

    always_comb begin
        for (int i = 0; i < `FETCH_PARA; i++) begin
            next_wen[i] = load.mode & load.valid & (int'(load_a.f.slot) == i);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            access_valid_q <= 1'b0;
            wen            <= '0;
            mode_q         <= 1'b0;
            last_found     <= '0;
        end else begin
            access_valid_q <= next_access.valid;
            wen            <= next_wen;
            mode_q         <= load.mode;
            last_found     <= next_last_found;
        end
    end

    always_ff @(posedge clk) begin
        access_addr_q <= next_access.addr;
        wdata         <= load.data;
    end

    assign access = {access_valid_q, access_addr_q};

    // one cycle pulse as load mode ends
    assign flush = mode_q & ~load.mode;

endmodule

// File: fetch/fetch_timing.sv
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_timing
    import fetch_pkg::*;
#(
    parameter int LEN_MEMISTR_ADDR = `LEN_MEMISTR_ADDR,
    parameter int FIND_PARA        = 1
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  mem_access_t                                 access,
    output logic                                        done,
    output logic [LEN_MEMISTR_ADDR-1:0]                 line,
    input  logic [FIND_PARA-1:0][LEN_MEMISTR_ADDR-1:0]  find_lines,
    output logic [FIND_PARA-1:0]                        found
);

    logic                        valid1;
    logic                        valid2;
    logic [LEN_MEMISTR_ADDR-1:0] line1;
    logic [LEN_MEMISTR_ADDR-1:0] line2;

    // stages follow the memory's address and data registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
        end else begin
            valid1 <= access.valid;
            valid2 <= valid1;
        end
    end

    always_ff @(posedge clk) begin
        line1 <= access.addr;
        line2 <= line1;
    end

    assign done = valid2;
    assign line = line2;

    always_comb begin
        for (int p = 0; p < FIND_PARA; p++) begin
            found[p] = (access.valid && find_lines[p] == access.addr)
                     | (valid1 && find_lines[p] == line1)
                     | (valid2 && find_lines[p] == line2);
        end
    end

endmodule

// File: fetch/line_cache.sv
`timescale 1ns/1ps
`include "fetch_config.svh"

module line_cache
    import fetch_pkg::*;
#(
    parameter int DEPTH     = `DEPTH_FETCH_CACHE,
    parameter int NUM_PORTS = 1
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          flush,
    input  logic                          fill_valid,
    input  line_addr_t                    fill_line,
    input  cache_line_t                   fill_data,
    input  line_addr_t  [NUM_PORTS-1:0]   look_lines,
    output logic        [NUM_PORTS-1:0]   hits,
    output cache_line_t [NUM_PORTS-1:0]   look_data
);

    logic                     fill_q_valid;
    line_addr_t               fill_q_line;
    cache_line_t              fill_q_data;
    logic [DEPTH-1:0]         valid;
    line_addr_t               tags [DEPTH];
    cache_line_t              lines [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic                     present;
    logic                     do_write;

    always_comb begin
        present = 1'b0;
        for (int e = 0; e < DEPTH; e++) begin
            if (valid[e] && tags[e] == fill_q_line) begin
                present = 1'b1;
            end
        end
    end

    // duplicate fills from refetches are dropped here
    assign do_write = fill_q_valid & ~present & ~flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_q_valid <= 1'b0;
            valid        <= '0;
            wr_ptr       <= '0;
        end else if (flush) begin
            fill_q_valid <= 1'b0;
            valid        <= '0;
            wr_ptr       <= '0;
        end else begin
            fill_q_valid <= fill_valid;
            if (do_write) begin
                valid[wr_ptr] <= 1'b1;
                wr_ptr        <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        fill_q_line <= fill_line;
        fill_q_data <= fill_data;
        if (do_write) begin
            tags[wr_ptr]  <= fill_q_line;
            lines[wr_ptr] <= fill_q_data;
        end
    end

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            hits[p]      = 1'b0;
            look_data[p] = '0;
            for (int e = 0; e < DEPTH; e++) begin
                if (valid[e] && tags[e] == look_lines[p]) begin
                    hits[p]      = 1'b1;
                    look_data[p] = lines[e];
                end
            end
        end
    end

endmodule

// File: fetch_unit.f
+incdir+common
common/fetch_pkg.sv
common/load_pkg.sv
fetch/fetch_timing.sv
fetch/line_cache.sv
fetch/fetch_ctrl.sv
hw/instr_mem.sv
hw/fetch_unit.sv
test/fetch_unit_sva.sv
test/fetch_unit_tb.sv

// File: hw/fetch_unit.sv
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_unit
    import fetch_pkg::*;
    import load_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  fetch_req_t           req,
    input  logic [`LEN_WORD-1:0] lr,
    input  load_req_t            load,
    output logic                 done,
    output logic [`LEN_INST-1:0] instr
);

    localparam int NUM_LOOK = `FETCH_PREDICT_SIZE + 2;

    fetch_addr_u                             pc_a;
    line_addr_t                              req_line;
    line_addr_t                              hint_line;
    line_addr_t [`FETCH_PREDICT_SIZE-1:0]    predict_lines;
    line_addr_t [NUM_LOOK-1:0]               look_lines;
    logic [NUM_LOOK-1:0]                     hits;
    logic [NUM_LOOK-1:0]                     in_flight;
    cache_line_t [NUM_LOOK-1:0]              look_data;
    mem_access_t                             access;
    slot_wen_t                               wen;
    logic [`LEN_INST-1:0]                    wdata;
    logic                                    flush;
    logic                                    fill_valid;
    line_addr_t                              fill_line;
    cache_line_t                             mem_data;

    // port 0 request, 1 hint, then the candidates
    assign look_lines = {predict_lines, hint_line, req_line};

    fetch_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .lr            (lr),
        .load          (load),
        .hit           (hits[0]),
        .req_line      (req_line),
        .hint_line     (hint_line),
        .predict_lines (predict_lines),
        .predict_hit   (hits[NUM_LOOK-1:2]),
        .predict_busy  (in_flight[NUM_LOOK-1:2]),
        .hint_hit      (hits[1]),
        .hint_busy     (in_flight[1]),
        .access        (access),
        .wen           (wen),
        .wdata         (wdata),
        .flush         (flush)
    );

    fetch_timing #(
        .LEN_MEMISTR_ADDR (`LEN_MEMISTR_ADDR),
        .FIND_PARA        (NUM_LOOK)
    ) u_timing (
        .clk        (clk),
        .rst_n      (rst_n),
        .access     (access),
        .done       (fill_valid),
        .line       (fill_line),
        .find_lines (look_lines),
        .found      (in_flight)
    );

    line_cache #(
        .DEPTH     (`DEPTH_FETCH_CACHE),
        .NUM_PORTS (NUM_LOOK)
    ) u_cache (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .fill_valid (fill_valid),
        .fill_line  (fill_line),
        .fill_data  (mem_data),
        .look_lines (look_lines),
        .hits       (hits),
        .look_data  (look_data)
    );

    // write line rides on the access address in load mode
    instr_mem u_mem (
        .clk    (clk),
        .rst_n  (rst_n),
        .access (access),
        .data   (mem_data),
        .wen    (wen),
        .waddr  (access.addr),
        .wdata  (wdata)
    );

    assign pc_a  = req.pc;
    assign done  = req.order & hits[0];
    assign instr = look_data[0][pc_a.f.slot];

endmodule

// File: hw/instr_mem.sv
`timescale 1ns/1ps
`include "fetch_config.svh"

module instr_mem
    import fetch_pkg::*;
    import load_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  mem_access_t          access,
    output cache_line_t          data,
    input  slot_wen_t            wen,
    input  line_addr_t           waddr,
    input  logic [`LEN_INST-1:0] wdata
);

    cache_line_t mem [2**`LEN_MEMISTR_ADDR];
    line_addr_t  rd_addr_q;
    logic        rd_en_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_en_q <= 1'b0;
        end else begin
            rd_en_q <= access.valid;
        end
    end

    // data stage only moves on a real read
    always_ff @(posedge clk) begin
        rd_addr_q <= access.addr;
        if (rd_en_q) begin
            data <= mem[rd_addr_q];
        end
        for (int i = 0; i < `FETCH_PARA; i++) begin
            if (wen[i]) begin
                mem[waddr][i] <= wdata;
            end
        end
    end

endmodule

// File: test/fetch_unit_sva.sv
`timescale 1ns/1ps

module fetch_unit_sva
    import fetch_pkg::*;
    import load_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input fetch_req_t  req,
    input load_req_t   load,
    input logic        done,
    input mem_access_t access,
    input logic        fill_valid,
    input logic        flush
);

    int   fail_count = 0;
    logic seen_order;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen_order <= 1'b0;
        end else if (req.order) begin
            seen_order <= 1'b1;
        end
    end

    no_done_without_order: assert property (
        @(posedge clk) disable iff (!rst_n) done |-> req.order
    ) else begin
        $error("done high while order is low");
        fail_count++;
    end

    // nothing can be cached before the first order
    quiet_after_reset: assert property (
        @(posedge clk) disable iff (!rst_n) !seen_order |-> !done
    ) else begin
        $error("done high before the first order after reset");
        fail_count++;
    end

    hold_until_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        (req.order && !done) |=> (req.order && $stable(req.pc))
    ) else begin
        $error("order or pc changed before done");
        fail_count++;
    end

    load_blocks_access: assert property (
        @(posedge clk) disable iff (!rst_n) load.mode |=> !access.valid
    ) else begin
        $error("memory read issued in load mode");
        fail_count++;
    end

    // tracker done lines up with the two-cycle memory read
    fill_follows_access: assert property (
        @(posedge clk) disable iff (!rst_n) fill_valid |-> $past(access.valid, 2)
    ) else begin
        $error("fill without a read two cycles earlier");
        fail_count++;
    end

    flush_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) flush |=> !flush
    ) else begin
        $error("flush held longer than one cycle");
        fail_count++;
    end

endmodule

bind fetch_unit fetch_unit_sva u_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .load       (load),
    .done       (done),
    .access     (access),
    .fill_valid (fill_valid),
    .flush      (flush)
);

// File: test/fetch_unit_tb.sv
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_unit_tb
    import fetch_pkg::*;
    import load_pkg::*;
();

    localparam int NUM_WORDS    = 32;
    localparam int DONE_TIMEOUT = 60;
    localparam int IDX_W        = `LEN_MEMISTR_ADDR + `LOG_FETCH_PARA;

    typedef logic [IDX_W-1:0] word_idx_t;

    logic                 clk;
    logic                 rst_n;
    fetch_req_t           req;
    logic [`LEN_WORD-1:0] lr;
    load_req_t            load;
    logic                 done;
    logic [`LEN_INST-1:0] instr;

    logic [`LEN_INST-1:0] model [2**IDX_W];
    word_idx_t            word_order [NUM_WORDS];
    logic [31:0]          lfsr_state;
    logic                 expect_done_now;
    logic                 expect_no_done;
    int                   errors;
    int                   tests_passed;
    int                   tests_failed;

    fetch_unit uut (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .lr    (lr),
        .load  (load),
        .done  (done),
        .instr (instr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic word_idx_t word_index(input logic [`LEN_WORD-1:0] pc);
        fetch_addr_u a;
        a.word = pc;
        return {a.f.line, a.f.slot};
    endfunction

    function automatic logic [`LEN_WORD-1:0] word_pc(input word_idx_t w);
        fetch_addr_u a;
        a.word              = '0;
        {a.f.line, a.f.slot} = w;
        return a.word;
    endfunction

    instr_matches_model: assert property (
        @(posedge clk) disable iff (!rst_n)
        (req.order && done) |-> instr == model[word_index(req.pc)]
    ) else begin
        $display("** Error at %0t ns: instr = %h, expected %h", $time, $sampled(instr),
                 model[word_index($sampled(req.pc))]);
        errors++;
    end

    done_at_once: assert property (
        @(posedge clk) disable iff (!rst_n) expect_done_now |-> done
    ) else begin
        $display("** Error at %0t ns: done = %b, expected 1", $time, $sampled(done));
        errors++;
    end

    no_done_in_load: assert property (
        @(posedge clk) disable iff (!rst_n) expect_no_done |-> !done
    ) else begin
        $display("done went high for an uncached line during load mode at %0t ns", $time);
        errors++;
    end

    task automatic load_word(input word_idx_t w, input logic [`LEN_INST-1:0] data);
        @(negedge clk);
        load.valid = 1'b1;
        load.pc    = word_pc(w);
        load.data  = data;
        model[w]   = data;
    endtask

    task automatic wait_done(input logic [`LEN_WORD-1:0] pc);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < DONE_TIMEOUT) begin
            @(posedge clk);
            seen = done;
            waited++;
        end
        if (!seen) begin
            $display("timeout: no done for pc %h after %0d cycles", pc, waited);
            errors++;
        end
    endtask

    task automatic fetch_word(input logic [`LEN_WORD-1:0] pc, input logic at_once);
        @(negedge clk);
        req.order       = 1'b1;
        req.pc          = pc;
        expect_done_now = at_once;
        wait_done(pc);
        @(negedge clk);
        req.order       = 1'b0;
        expect_done_now = 1'b0;
    endtask

    // leaving load mode invalidates the cache
    task automatic pulse_load_mode();
        @(negedge clk);
        load.mode = 1'b1;
        repeat (6) @(negedge clk);
        load.mode = 1'b0;
    endtask

    task automatic report_test(input string name, input int start);
        if (errors == start) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - start);
        end
    endtask

    initial begin
        int        start;
        int        j;
        int        line_l;
        int        line_h;
        word_idx_t tmp;
        lfsr_state      = 32'hb063;
        rst_n           = 1'b0;
        req             = '0;
        lr              = '0;
        load            = '0;
        load.mode       = 1'b1;
        expect_done_now = 1'b0;
        expect_no_done  = 1'b0;
        errors          = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        for (int w = 0; w < NUM_WORDS; w++) begin
            load_word(word_idx_t'(w), rand_bits(32));
        end
        @(negedge clk);
        load.valid = 1'b0;

        start = errors;
        tmp   = word_idx_t'(rand_bits(5));
        @(negedge clk);
        req.order      = 1'b1;
        req.pc         = word_pc(tmp);
        expect_no_done = 1'b1;
        repeat (20) @(negedge clk);
        expect_no_done = 1'b0;
        load.mode      = 1'b0;
        wait_done(req.pc);
        @(negedge clk);
        req.order = 1'b0;
        report_test("request held in load mode", start);

        start = errors;
        for (int i = 0; i < NUM_WORDS; i++) begin
            word_order[i] = word_idx_t'(i);
        end
        for (int i = NUM_WORDS - 1; i > 0; i--) begin
            j             = int'(rand_bits(5) % (i + 1));
            tmp           = word_order[i];
            word_order[i] = word_order[j];
            word_order[j] = tmp;
        end
        for (int i = 0; i < NUM_WORDS; i++) begin
            fetch_word(word_pc(word_order[i]), 1'b0);
        end
        report_test("fetch all words", start);

        start  = errors;
        line_l = int'(rand_bits(4) % 13);
        for (int k = 1; k <= 3; k++) begin
            pulse_load_mode();
            fetch_word(word_pc(word_idx_t'(line_l * `FETCH_PARA)), 1'b0);
            repeat (16) @(negedge clk);
            tmp = word_idx_t'((line_l + k) * `FETCH_PARA + int'(rand_bits(1)));
            fetch_word(word_pc(tmp), 1'b1);
        end
        report_test("sequential prefetch", start);

        start  = errors;
        // hint line kept clear of the sequential window around the last line found
        line_h = (line_l + 7 + int'(rand_bits(3))) % 16;
        @(negedge clk);
        lr = word_pc(word_idx_t'(line_h * `FETCH_PARA));
        pulse_load_mode();
        repeat (16) @(negedge clk);
        fetch_word(word_pc(word_idx_t'(line_h * `FETCH_PARA + 1)), 1'b1);
        report_test("hint prefetch", start);

        start = errors;
        tmp   = word_idx_t'(rand_bits(5));
        // old word goes into the cache first
        fetch_word(word_pc(tmp), 1'b0);
        @(negedge clk);
        load.mode = 1'b1;
        repeat (4) @(negedge clk);
        load_word(tmp, rand_bits(32));
        @(negedge clk);
        load.valid = 1'b0;
        repeat (4) @(negedge clk);
        load.mode = 1'b0;
        fetch_word(word_pc(tmp), 1'b0);
        report_test("reload and flush", start);

        start  = errors;
        errors = errors + uut.u_sva.fail_count;
        report_test("protocol assertions", start);

        $display("%0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
